// ==== source/super_res_pkg.sv ====
package super_res_pkg;

  // Frame geometry in pixel clocks and lines
  localparam int unsigned displayed_width = 720;
  localparam int unsigned frame_width_ntsc = 858;
  localparam int unsigned frame_width_pal = 864;
  localparam int unsigned frame_height_ntsc = 525;
  localparam int unsigned frame_height_pal = 625;
  localparam int unsigned displayed_height_ntsc = 480;
  localparam int unsigned displayed_height_pal = 576;

  localparam int unsigned words_per_line = displayed_width / 4;  // One word per 4 pixels

  // Sync windows
  localparam int unsigned hsync_start = 736;
  localparam int unsigned hsync_end = 800;
  localparam int unsigned vsync_line_ntsc = 490;
  localparam int unsigned vsync_line_pal = 590;

  // Fetch schedule points in horizontal blank
  localparam int unsigned addr_load_cx = 720;  // Address back to 0 on last line
  localparam int unsigned idx_reset_cx = 722;  // Line buffer index restart
  localparam int unsigned prefetch_cx = 724;  // First word of the frame

  localparam int unsigned vram_depth = 65536;

  typedef logic [15:0] vram_addr_t;
  typedef logic [31:0] vram_word_t;

  typedef enum logic [1:0] {
    off = 2'd0,
    super_colour = 2'd1,  // 24-bit RGB, 4x4 pixels per word
    super_mid = 2'd2  // RGB565, 4x2 pixels per word
  } colour_mode_t;

  // Beam position with everything decoded from it
  typedef struct packed {
    logic [10:0] cx;
    logic [9:0] cy;
    logic visible;
    logic last_line;
    logic hsync;
    logic vsync;
  } beam_t;

  typedef struct packed {
    vram_addr_t addr;
    vram_word_t data;
  } host_write_t;

  typedef struct packed {
    logic de;
    logic hsync;
    logic vsync;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } video_t;

endpackage

// ==== source/video_timing.sv ====
module video_timing (
  input  logic clk,
  input  logic reset,
  input  logic pal_mode,
  output super_res_pkg::beam_t beam
);

  logic [10:0] h_cnt;
  logic [9:0] v_cnt;
  logic pal_q;  // Standard of the frame in progress
  logic [10:0] h_last;
  logic [9:0] v_last;
  logic [9:0] v_shown;
  logic [9:0] v_sync;

  // Wrap points and windows for the current standard
  assign h_last = pal_q ? 11'(super_res_pkg::frame_width_pal - 1)
                        : 11'(super_res_pkg::frame_width_ntsc - 1);
  assign v_last = pal_q ? 10'(super_res_pkg::frame_height_pal - 1)
                        : 10'(super_res_pkg::frame_height_ntsc - 1);
  assign v_shown = pal_q ? 10'(super_res_pkg::displayed_height_pal)
                         : 10'(super_res_pkg::displayed_height_ntsc);
  assign v_sync = pal_q ? 10'(super_res_pkg::vsync_line_pal)
                        : 10'(super_res_pkg::vsync_line_ntsc);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
      pal_q <= 1'b0;
    end else if (h_cnt == h_last) begin
      h_cnt <= '0;
      if (v_cnt == v_last) begin
        v_cnt <= '0;
        pal_q <= pal_mode;  // Standard switches only at frame start
      end else begin
        v_cnt <= v_cnt + 10'd1;
      end
    end else begin
      h_cnt <= h_cnt + 11'd1;
    end
  end

  // All flags registered in one go so consumers see a single position
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      beam <= '0;
    end else begin
      beam.cx <= h_cnt;
      beam.cy <= v_cnt;
      beam.visible <= (h_cnt < super_res_pkg::displayed_width) && (v_cnt < v_shown);
      beam.last_line <= v_cnt == v_last;
      beam.hsync <= (h_cnt >= super_res_pkg::hsync_start) && (h_cnt < super_res_pkg::hsync_end);
      beam.vsync <= v_cnt == v_sync;
    end
  end

  h_cnt_in_line: assert property (@(posedge clk) disable iff (reset)
    h_cnt < (pal_q ? super_res_pkg::frame_width_pal : super_res_pkg::frame_width_ntsc));

endmodule

// ==== source/vram_store.sv ====
module vram_store (
  input  logic clk,
  input  logic reset,
  input  logic rd_en,
  input  super_res_pkg::vram_addr_t rd_addr,
  output super_res_pkg::vram_word_t rd_data,
  input  logic host_valid,
  output logic host_ready,
  input  super_res_pkg::host_write_t host_write
);

  super_res_pkg::vram_word_t mem [super_res_pkg::vram_depth];

  logic wr_fire;
  super_res_pkg::vram_addr_t port_addr;

  // The display always wins the single port
  assign host_ready = !rd_en;
  assign wr_fire = host_valid && host_ready;

  // One address bus shared by both users
  assign port_addr = rd_en ? rd_addr : host_write.addr;

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[port_addr];  // Data ready one cycle after rd_en
    end else if (wr_fire) begin
      mem[port_addr] <= host_write.data;
    end
  end

  // Port is used by one side per cycle
  one_op_per_cycle: assert property (@(posedge clk) disable iff (reset)
    !(wr_fire && rd_en));

  // A stalled host keeps its request steady until it lands
  host_hold: assert property (@(posedge clk) disable iff (reset)
    host_valid && !host_ready |=> host_valid && $stable(host_write));

endmodule

// ==== source/super_res_fetch.sv ====
module super_res_fetch (
  input  logic clk,
  input  logic reset,
  input  super_res_pkg::colour_mode_t mode,
  input  logic disp_on,
  input  super_res_pkg::beam_t beam_in,
  output logic rd_en,
  output super_res_pkg::vram_addr_t rd_addr,
  input  super_res_pkg::vram_word_t rd_data,
  output logic word_valid,
  output super_res_pkg::vram_word_t word,
  output super_res_pkg::beam_t beam_out
);

  logic fetch_run;
  logic active_line;  // Line drawn from VRAM, otherwise replayed from line buffer
  logic present_slot;
  logic read_slot;
  logic prefetch_slot;
  logic rd_pending;
  logic [7:0] lb_idx;
  super_res_pkg::vram_addr_t addr_q;
  super_res_pkg::vram_word_t next_word;  // Word for the coming pixel group
  super_res_pkg::vram_word_t fill_word;
  super_res_pkg::vram_word_t line_buf [super_res_pkg::words_per_line];

  assign fetch_run = mode != super_res_pkg::off;

  // Line repeat of 4 in super colour, 2 in super mid
  always_comb begin
    case (mode)
      super_res_pkg::super_colour: active_line = beam_in.cy[1:0] == 2'b00;
      super_res_pkg::super_mid: active_line = !beam_in.cy[0];
      default: active_line = 1'b0;
    endcase
  end

  // Four-phase group: present at phase 0, read at phase 1
  assign present_slot = fetch_run && beam_in.visible && (beam_in.cx[1:0] == 2'd0);
  assign read_slot = fetch_run && beam_in.visible && active_line && (beam_in.cx[1:0] == 2'd1);

  // First word of the frame is pulled in during blank of the last line
  assign prefetch_slot = fetch_run && beam_in.last_line
                         && (beam_in.cx == super_res_pkg::prefetch_cx);

  assign rd_en = read_slot || prefetch_slot;
  assign rd_addr = addr_q;

  assign fill_word = disp_on ? next_word : '0;  // Blanked picture is black

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      addr_q <= '0;
      lb_idx <= '0;
      rd_pending <= 1'b0;
      word_valid <= 1'b0;
    end else if (!fetch_run) begin
      // Held idle while the mode is off
      addr_q <= '0;
      lb_idx <= '0;
      rd_pending <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      rd_pending <= rd_en;
      word_valid <= beam_in.visible;

      // Address only restarts at end of frame
      if (beam_in.last_line && (beam_in.cx == super_res_pkg::addr_load_cx)) begin
        addr_q <= '0;
      end else if (present_slot && active_line) begin
        addr_q <= addr_q + 16'd1;
      end

      if (beam_in.cx == super_res_pkg::idx_reset_cx) begin
        lb_idx <= '0;
      end else if (present_slot) begin
        lb_idx <= lb_idx + 8'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pending) begin
      next_word <= rd_data;  // Returned word lands at phase 2 or cx 725
    end
    if (present_slot) begin
      if (active_line) begin
        line_buf[lb_idx] <= fill_word;
        word <= fill_word;
      end else begin
        word <= line_buf[lb_idx];  // Repeated line, no VRAM traffic
      end
    end
  end

  // Beam follows the word with the same one cycle delay
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      beam_out <= '0;
    end else begin
      beam_out <= beam_in;
    end
  end

  lb_idx_range: assert property (@(posedge clk) disable iff (reset)
    present_slot |-> lb_idx < super_res_pkg::words_per_line);

  rd_only_when_needed: assert property (@(posedge clk) disable iff (reset)
    rd_en |-> (beam_in.visible ? active_line : prefetch_slot));

endmodule

// ==== source/pixel_unpack.sv ====
module pixel_unpack (
  input  logic clk,
  input  logic reset,
  input  super_res_pkg::colour_mode_t mode,
  input  logic word_valid,
  input  super_res_pkg::vram_word_t word,
  input  super_res_pkg::beam_t beam_in,
  output super_res_pkg::video_t video
);

  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;
  super_res_pkg::video_t next_video;

  always_comb begin
    case (mode)
      super_res_pkg::super_colour: begin
        red = word[23:16];
        green = word[15:8];
        blue = word[7:0];
      end
      super_res_pkg::super_mid: begin
        // RGB565 widened by zero fill
        red = {word[15:11], 3'b000};
        green = {word[10:5], 2'b00};
        blue = {word[4:0], 3'b000};
      end
      default: begin
        red = '0;
        green = '0;
        blue = '0;
      end
    endcase
  end

  always_comb begin
    next_video.de = word_valid;
    next_video.hsync = beam_in.hsync;
    next_video.vsync = beam_in.vsync;
    next_video.red = word_valid ? red : 8'd0;  // Black outside the picture
    next_video.green = word_valid ? green : 8'd0;
    next_video.blue = word_valid ? blue : 8'd0;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      video <= '0;
    end else begin
      video <= next_video;
    end
  end

endmodule

// ==== source/super_res_top.sv ====
module super_res_top (
  input  logic clk,
  input  logic reset,
  input  logic pal_mode,
  input  logic disp_on,
  input  super_res_pkg::colour_mode_t mode,
  input  logic host_valid,
  output logic host_ready,
  input  super_res_pkg::host_write_t host_write,
  output super_res_pkg::video_t video
);

  super_res_pkg::beam_t timing_beam;
  super_res_pkg::beam_t fetch_beam;  // Delayed to match word
  logic rd_en;
  super_res_pkg::vram_addr_t rd_addr;
  super_res_pkg::vram_word_t rd_data;
  logic word_valid;
  super_res_pkg::vram_word_t word;

  video_timing u_timing (
    .clk      (clk),
    .reset    (reset),
    .pal_mode (pal_mode),
    .beam     (timing_beam)
  );

  vram_store u_vram (
    .clk        (clk),
    .reset      (reset),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .host_valid (host_valid),
    .host_ready (host_ready),
    .host_write (host_write)
  );

  super_res_fetch u_fetch (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .disp_on    (disp_on),
    .beam_in    (timing_beam),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .word_valid (word_valid),
    .word       (word),
    .beam_out   (fetch_beam)
  );

  pixel_unpack u_unpack (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .word_valid (word_valid),
    .word       (word),
    .beam_in    (fetch_beam),
    .video      (video)
  );

endmodule

// ==== sim/super_res_checker.sv ====
module super_res_checker (
  input  logic clk,
  input  logic reset,
  input  super_res_pkg::video_t video,
  input  logic pal_mode,
  input  logic disp_on,
  input  super_res_pkg::colour_mode_t mode,
  input  logic host_valid,
  input  logic host_ready,
  input  super_res_pkg::host_write_t host_write,
  output int frames_done,
  output int pixel_errors,
  output int geometry_errors,
  output int sync_errors
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int line_words = 180;
  localparam int image_words = line_words * 576 / 2;
  localparam int hsync_cycles = super_res_pkg::hsync_end - super_res_pkg::hsync_start;
  localparam int max_reports = 20;

  super_res_pkg::vram_word_t image [super_res_pkg::vram_depth];  // Host view of VRAM
  int write_frame [super_res_pkg::vram_depth];  // Frame in which a word last changed

  int frame_no;
  int x;
  int y;
  int hs_len;
  logic started;  // A whole frame is being tracked
  logic prev_de;
  logic prev_hsync;
  logic prev_vsync;
  super_res_pkg::colour_mode_t cfg_mode;
  logic cfg_disp;
  logic cfg_pal;

  // Expected colour of pixel (col, line) counted from the frame's first de line
  function automatic logic [23:0] expected_rgb(input int line, input int col,
                                               input super_res_pkg::colour_mode_t m,
                                               input logic on, output int index);
    int lines_per_word;
    super_res_pkg::vram_word_t w;
    lines_per_word = (m == super_res_pkg::super_colour) ? 4 : 2;
    index = (line / lines_per_word) * line_words + col / 4;
    w = (index < image_words) ? image[index] : '0;
    if (!on) return 24'd0;
    if (m == super_res_pkg::super_colour) return w[23:0];
    return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};  // RGB565 widened
  endfunction

  task automatic flag_pixel(input int col, input int line, input logic [23:0] got,
                            input logic [23:0] want);
    pixel_errors++;
    if (pixel_errors <= max_reports) begin
      $display("error %0t: pixel (%0d,%0d) is %h, expected %h", $time, col, line, got, want);
    end
  endtask

  initial begin
    for (int i = 0; i < super_res_pkg::vram_depth; i++) begin
      write_frame[i] = -1;
    end
  end

  always @(posedge clk) begin
    logic [23:0] want;
    int index;
    int want_lines;
    if (reset) begin
      frames_done = 0;
      pixel_errors = 0;
      geometry_errors = 0;
      sync_errors = 0;
      frame_no = 0;
      x = 0;
      y = 0;
      hs_len = 0;
      started = 1'b0;
      prev_de = 1'b0;
      prev_hsync = 1'b0;
      prev_vsync = 1'b0;
    end else begin
      if (host_valid && host_ready) begin
        image[host_write.addr] = host_write.data;
        write_frame[host_write.addr] = frame_no;  // May or may not land in this frame
      end

      if (video.hsync) begin
        hs_len++;
      end else if (prev_hsync) begin
        if (hs_len != hsync_cycles) begin
          sync_errors++;
          $display("error %0t: hsync high for %0d cycles, expected %0d", $time, hs_len,
                   hsync_cycles);
        end
        hs_len = 0;
      end

      if (video.de) begin
        if (started && cfg_mode != super_res_pkg::off) begin
          want = expected_rgb(y, x, cfg_mode, cfg_disp, index);
          if (index >= image_words) begin
            flag_pixel(x, y, {video.red, video.green, video.blue}, want);
          end else if (write_frame[index] != frame_no
                       && {video.red, video.green, video.blue} !== want) begin
            flag_pixel(x, y, {video.red, video.green, video.blue}, want);
          end
        end
        x++;
      end else if (prev_de) begin
        if (started && x != super_res_pkg::displayed_width) begin
          geometry_errors++;
          $display("error %0t: line %0d has %0d de pixels, expected 720", $time, y, x);
        end
        y++;
        x = 0;
      end

      if (video.vsync && !prev_vsync) begin
        if (cfg_mode == super_res_pkg::off) want_lines = 0;
        else want_lines = cfg_pal ? 576 : 480;
        if (started && y != want_lines) begin
          geometry_errors++;
          $display("error %0t: frame has %0d de lines, expected %0d", $time, y, want_lines);
        end
        if (started) frames_done++;
        frame_no++;
        x = 0;
        y = 0;
      end else if (!video.vsync && prev_vsync) begin
        cfg_mode = mode;  // Setup for the frame that follows
        cfg_disp = disp_on;
        cfg_pal = pal_mode;
        started = 1'b1;
      end

      prev_de = video.de;
      prev_hsync = video.hsync;
      prev_vsync = video.vsync;
    end
  end

endmodule

// ==== sim/tb_super_res.sv ====
module tb_super_res;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int image_words = 180 * 576 / 2;
  localparam int frame_cycles = 864 * 625;  // Longest frame
  localparam int write_timeout = 64;
  localparam int live_writes = 300;

  logic clk;
  logic reset;
  logic pal_mode;
  logic disp_on;
  super_res_pkg::colour_mode_t mode;
  logic host_valid;
  logic host_ready;
  super_res_pkg::host_write_t host_write;
  super_res_pkg::video_t video;

  int frames_done;
  int pixel_errors;
  int geometry_errors;
  int sync_errors;
  int host_errors;
  int stall_total;
  logic timed_out;
  logic [15:0] lfsr;

  super_res_top dut (
    .clk        (clk),
    .reset      (reset),
    .pal_mode   (pal_mode),
    .disp_on    (disp_on),
    .mode       (mode),
    .host_valid (host_valid),
    .host_ready (host_ready),
    .host_write (host_write),
    .video      (video)
  );

  super_res_checker watcher (
    .clk             (clk),
    .reset           (reset),
    .video           (video),
    .pal_mode        (pal_mode),
    .disp_on         (disp_on),
    .mode            (mode),
    .host_valid      (host_valid),
    .host_ready      (host_ready),
    .host_write      (host_write),
    .frames_done     (frames_done),
    .pixel_errors    (pixel_errors),
    .geometry_errors (geometry_errors),
    .sync_errors     (sync_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic send_write(input super_res_pkg::vram_addr_t addr,
                            input super_res_pkg::vram_word_t data, output int stalls);
    stalls = 0;
    if (timed_out) return;
    host_write.addr = addr;
    host_write.data = data;
    host_valid = 1'b1;
    while (!host_ready && stalls < write_timeout) begin
      @(negedge clk);
      stalls++;
    end
    if (!host_ready) begin
      $display("timeout: host write to %h was never accepted", addr);
      timed_out = 1'b1;
    end else begin
      @(negedge clk);  // Taken on the rising edge in between
    end
    host_valid = 1'b0;
  endtask

  task automatic wait_vsync();
    int cycles;
    cycles = 0;
    if (timed_out) return;
    while (video.vsync && cycles < 2 * frame_cycles) begin
      @(negedge clk);
      cycles++;
    end
    while (!video.vsync && cycles < 2 * frame_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!video.vsync) begin
      $display("timeout: no vsync seen within two frames");
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_de();
    int cycles;
    cycles = 0;
    if (timed_out) return;
    while (!video.de && cycles < 2 * frame_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!video.de) begin
      $display("timeout: display never enabled a pixel");
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_frames(input int n);
    int cycles;
    int target;
    cycles = 0;
    target = frames_done + n;
    if (timed_out) return;
    while (frames_done < target && cycles < (n + 2) * frame_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (frames_done < target) begin
      $display("timeout: checker finished %0d of %0d frames", frames_done, target);
      timed_out = 1'b1;
    end
  endtask

  // New setup is applied during the vsync line
  task automatic change_setup(input logic pal, input super_res_pkg::colour_mode_t m,
                              input logic on);
    if (!video.vsync) wait_vsync();
    pal_mode = pal;
    mode = m;
    disp_on = on;
    @(negedge clk);
  endtask

  initial begin
    int stalls;
    reset = 1'b1;
    pal_mode = 1'b0;
    disp_on = 1'b1;
    mode = super_res_pkg::off;
    host_valid = 1'b0;
    host_write = '0;
    host_errors = 0;
    stall_total = 0;
    timed_out = 1'b0;
    lfsr = 16'd72;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Whole image loaded while the display is idle
    for (int a = 0; a < image_words; a++) begin
      send_write(16'(a), random_bits(32), stalls);
      if (stalls != 0) begin
        host_errors++;
        $display("error %0t: write %0d stalled %0d cycles with mode off", $time, a, stalls);
      end
    end
    wait_frames(1);

    change_setup(1'b0, super_res_pkg::super_colour, 1'b1);
    wait_frames(2);
    change_setup(1'b1, super_res_pkg::super_mid, 1'b1);
    wait_frames(2);
    change_setup(1'b1, super_res_pkg::super_mid, 1'b0);
    wait_frames(1);

    // Writes racing the fetcher, checked in the frame after
    change_setup(1'b1, super_res_pkg::super_mid, 1'b1);
    wait_de();
    for (int i = 0; i < live_writes; i++) begin
      send_write(16'(random_bits(16) % image_words), random_bits(32), stalls);
      stall_total += stalls;
    end
    if (!timed_out && stall_total == 0) begin
      host_errors++;
      $display("the host port never stalled while the display was reading");
    end
    wait_frames(2);

    $display("frames %0d, pixel errors %0d, geometry errors %0d, sync errors %0d, host errors %0d",
             frames_done, pixel_errors, geometry_errors, sync_errors, host_errors);
    if (!timed_out && pixel_errors + geometry_errors + sync_errors + host_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== all.f ====
source/super_res_pkg.sv
source/video_timing.sv
source/vram_store.sv
source/super_res_fetch.sv
source/pixel_unpack.sv
source/super_res_top.sv
sim/super_res_checker.sv
sim/tb_super_res.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
TOP ?= tb_super_res
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Errors found" $(LOG); then \
	  echo "Simulation failed"; \
	  exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
